// ==== fpu_ncomp.f ====
+incdir+rtl
+incdir+sim
rtl/fpu_pkg.sv
rtl/fp_classifier.sv
rtl/pipe_stage.sv
rtl/fp_ncomp.sv
rtl/fflags_csr.sv
rtl/fpu_ncomp_top.sv
sim/tb_fpu_ncomp.sv

// ==== rtl/fflags_csr.sv ====
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fflags_csr import fpu_pkg::*; (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          rsp_valid,
    input  logic                          rsp_ready,
    input  logic                          has_fflags,
    input  fflags_t [`NCOMP_LANES-1:0]    lane_fflags,
    input  logic                          csr_req,
    input  logic                          csr_clear,
    output logic                          csr_ack,
    output fflags_t                       csr_rdata
);

    typedef enum logic [1:0] {
        CSR_IDLE,
        CSR_ACK,
        CSR_WAIT
    } csr_state_e;

    csr_state_e state;
    fflags_t    accrued;
    fflags_t    new_flags;
    logic       start;

    always_comb begin
        new_flags = '0;
        if (rsp_valid && rsp_ready && has_fflags) begin
            for (int i = 0; i < `NCOMP_LANES; i++) begin
                new_flags = new_flags | lane_fflags[i];
            end
        end
    end

    assign start = (state == CSR_IDLE) && csr_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= CSR_IDLE;
        end else begin
            case (state)
                CSR_IDLE: if (csr_req) state <= CSR_ACK;
                CSR_ACK:  state <= csr_req ? CSR_WAIT : CSR_IDLE;
                CSR_WAIT: if (!csr_req) state <= CSR_IDLE;
                default:  state <= CSR_IDLE;
            endcase
        end
    end

    // New flags always win over a clear in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            accrued <= '0;
        end else if (start && csr_clear) begin
            accrued <= new_flags;
        end else begin
            accrued <= accrued | new_flags;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            csr_rdata <= accrued; // Value before any clear
        end
    end

    assign csr_ack = (state != CSR_IDLE);

endmodule

// ==== rtl/fp_classifier.sv ====
`timescale 1ns/1ps

module fp_classifier import fpu_pkg::*; (
    input  logic [7:0]  exponent,
    input  logic [22:0] mantissa,
    output fp_class_t   clss
);

    logic exp_zero;
    logic exp_ones;
    logic man_zero;
    logic nan;

    assign exp_zero = (exponent == 8'h00);
    assign exp_ones = (exponent == 8'hff);
    assign man_zero = (mantissa == 23'd0);
    assign nan      = exp_ones & ~man_zero;

    always_comb begin
        clss.is_zero      = exp_zero & man_zero;
        clss.is_subnormal = exp_zero & ~man_zero;
        clss.is_normal    = ~exp_zero & ~exp_ones;
        clss.is_inf       = exp_ones & man_zero;
        clss.is_nan       = nan;
        // Mantissa MSB set marks a quiet NaN
        clss.is_quiet     = nan & mantissa[22];
        clss.is_signaling = nan & ~mantissa[22];
    end

endmodule

// ==== rtl/fp_ncomp.sv ====
`timescale 1ns/1ps
`include "fpu_defines.svh"

module fp_ncomp import fpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       req_valid,
    output logic       req_ready,
    input  ncomp_req_t req,
    output logic       rsp_valid,
    input  logic       rsp_ready,
    output ncomp_rsp_t rsp
);

    localparam int          LANES     = `NCOMP_LANES;
    localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

    // Stage 0 payload
    typedef struct packed {
        ncomp_req_t             req;
        fp_class_t [LANES-1:0]  a_clss;
        fp_class_t [LANES-1:0]  b_clss;
        logic [LANES-1:0]       a_less;
        logic [LANES-1:0]       equal;
    } s0_t;

    fp_class_t [LANES-1:0]  a_clss;
    fp_class_t [LANES-1:0]  b_clss;
    logic [LANES-1:0]       a_less;
    logic [LANES-1:0]       equal;
    s0_t                    s0_d;
    s0_t                    s0_q;
    logic                   s0_valid;
    logic [LANES-1:0][31:0] lane_result;
    fflags_t [LANES-1:0]    lane_fflags;
    logic                   has_fflags_s0;
    ncomp_rsp_t             rsp_d;
    logic                   stall;

    for (genvar i = 0; i < LANES; i++) begin : g_lane_in
        logic both_zero;

        fp_classifier u_class_a (
            .exponent (req.dataa[i][30:23]),
            .mantissa (req.dataa[i][22:0]),
            .clss     (a_clss[i])
        );

        fp_classifier u_class_b (
            .exponent (req.datab[i][30:23]),
            .mantissa (req.datab[i][22:0]),
            .clss     (b_clss[i])
        );

        assign both_zero = a_clss[i].is_zero & b_clss[i].is_zero;
        assign equal[i]  = (req.dataa[i] == req.datab[i]) | both_zero; // -0 == +0

        always_comb begin
            if (req.dataa[i][31] != req.datab[i][31]) begin
                a_less[i] = req.dataa[i][31] & ~both_zero;
            end else if (req.dataa[i][31]) begin
                a_less[i] = req.dataa[i][30:0] > req.datab[i][30:0]; // Magnitude reversed
            end else begin
                a_less[i] = req.dataa[i][30:0] < req.datab[i][30:0];
            end
        end
    end

    always_comb begin
        s0_d.req    = req;
        s0_d.a_clss = a_clss;
        s0_d.b_clss = b_clss;
        s0_d.a_less = a_less;
        s0_d.equal  = equal;
    end

    assign stall     = rsp_valid & ~rsp_ready;
    assign req_ready = ~stall;

    pipe_stage #(.T(s0_t)) u_stage0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (~stall),
        .valid_in  (req_valid),
        .data_in   (s0_d),
        .valid_out (s0_valid),
        .data_out  (s0_q)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane_out
        fp_class_t   ca;
        fp_class_t   cb;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] fclass_mask;
        logic [31:0] minmax_res;
        logic        any_nan;
        logic        any_snan;
        logic        min_less;

        assign ca       = s0_q.a_clss[i];
        assign cb       = s0_q.b_clss[i];
        assign a        = s0_q.req.dataa[i];
        assign b        = s0_q.req.datab[i];
        assign any_nan  = ca.is_nan | cb.is_nan;
        assign any_snan = ca.is_signaling | cb.is_signaling;
        // Min/max orders -0 below +0
        assign min_less = s0_q.a_less[i] | (ca.is_zero & cb.is_zero & a[31] & ~b[31]);

        assign fclass_mask = {22'd0, ca.is_quiet, ca.is_signaling,
                              ~a[31] & ca.is_inf, ~a[31] & ca.is_normal,
                              ~a[31] & ca.is_subnormal, ~a[31] & ca.is_zero,
                              a[31] & ca.is_zero, a[31] & ca.is_subnormal,
                              a[31] & ca.is_normal, a[31] & ca.is_inf};

        always_comb begin
            if (ca.is_nan && cb.is_nan) begin
                minmax_res = CANON_NAN;
            end else if (ca.is_nan) begin
                minmax_res = b;
            end else if (cb.is_nan) begin
                minmax_res = a;
            end else if (s0_q.req.frm == `FRM_RTZ) begin
                minmax_res = min_less ? b : a; // FMAX
            end else begin
                minmax_res = min_less ? a : b;
            end
        end

        always_comb begin
            lane_result[i] = '0;
            lane_fflags[i] = '0;
            case (s0_q.req.op)
                `OP_CLASS: lane_result[i] = fclass_mask;
                `OP_CMP: begin
                    case (s0_q.req.frm)
                        `FRM_RNE: begin // FLE
                            lane_result[i][0] = ~any_nan & (s0_q.a_less[i] | s0_q.equal[i]);
                            lane_fflags[i].NV = any_nan;
                        end
                        `FRM_RTZ: begin // FLT
                            lane_result[i][0] = ~any_nan & s0_q.a_less[i];
                            lane_fflags[i].NV = any_nan;
                        end
                        `FRM_RDN: begin // FEQ is a quiet compare
                            lane_result[i][0] = ~any_nan & s0_q.equal[i];
                            lane_fflags[i].NV = any_snan;
                        end
                        default: ;
                    endcase
                end
                `OP_MISC: begin
                    case (s0_q.req.frm)
                        `FRM_RNE, `FRM_RTZ: begin
                            lane_result[i]    = minmax_res;
                            lane_fflags[i].NV = any_snan;
                        end
                        `FRM_RDN: lane_result[i] = {b[31], a[30:0]};
                        `FRM_RUP: lane_result[i] = {~b[31], a[30:0]};
                        `FRM_RMM: lane_result[i] = {a[31] ^ b[31], a[30:0]};
                        default:  lane_result[i] = a; // Move
                    endcase
                end
                default: ;
            endcase
        end
    end

    assign has_fflags_s0 = (s0_q.req.op == `OP_CMP)
                        || ((s0_q.req.op == `OP_MISC)
                            && (s0_q.req.frm == `FRM_RNE || s0_q.req.frm == `FRM_RTZ));

    always_comb begin
        rsp_d.tag        = s0_q.req.tag;
        rsp_d.result     = lane_result;
        rsp_d.has_fflags = has_fflags_s0;
        rsp_d.fflags     = lane_fflags;
    end

    pipe_stage #(.T(ncomp_rsp_t)) u_stage1 (
        .clk       (clk),
        .rst_n     (rst_n),
        .enable    (~stall),
        .valid_in  (s0_valid),
        .data_in   (rsp_d),
        .valid_out (rsp_valid),
        .data_out  (rsp)
    );

endmodule

// ==== rtl/fpu_defines.svh ====
`ifndef FPU_DEFINES_SVH
`define FPU_DEFINES_SVH

// Lane count and tag width
`define NCOMP_LANES 2
`define NCOMP_TAGW  4

// Operation codes
`define OP_BITS  2
`define OP_CLASS 2'd0
`define OP_CMP   2'd1
`define OP_MISC  2'd2

// The rounding field selects the sub-function
`define FRM_BITS 3

`define FRM_RNE 3'd0 // FLE, FMIN
`define FRM_RTZ 3'd1 // FLT, FMAX
`define FRM_RDN 3'd2 // FEQ, FSGNJ
`define FRM_RUP 3'd3 // FSGNJN
`define FRM_RMM 3'd4 // FSGNJX

`endif

// ==== rtl/fpu_ncomp_top.sv ====
`timescale 1ns/1ps

module fpu_ncomp_top import fpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,

    input  logic       req_valid,
    output logic       req_ready,
    input  ncomp_req_t req,

    output logic       rsp_valid,
    input  logic       rsp_ready,
    output ncomp_rsp_t rsp,

    input  logic       csr_req,
    input  logic       csr_clear,
    output logic       csr_ack,
    output fflags_t    csr_rdata
);

    fp_ncomp u_ncomp (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

    // Watches the response stream for completed flagged results
    fflags_csr u_fflags (
        .clk         (clk),
        .rst_n       (rst_n),
        .rsp_valid   (rsp_valid),
        .rsp_ready   (rsp_ready),
        .has_fflags  (rsp.has_fflags),
        .lane_fflags (rsp.fflags),
        .csr_req     (csr_req),
        .csr_clear   (csr_clear),
        .csr_ack     (csr_ack),
        .csr_rdata   (csr_rdata)
    );

endmodule

// ==== rtl/fpu_pkg.sv ====
`include "fpu_defines.svh"

package fpu_pkg;

    // IEEE exception flags in fcsr bit order
    typedef struct packed {
        logic NV; // Invalid operation
        logic DZ; // Divide by zero
        logic OF; // Overflow
        logic UF; // Underflow
        logic NX; // Inexact
    } fflags_t;

    // Operand class bits
    typedef struct packed {
        logic is_zero;
        logic is_subnormal;
        logic is_normal;
        logic is_inf;
        logic is_nan;
        logic is_quiet;
        logic is_signaling;
    } fp_class_t;

    // One tagged request for all lanes
    typedef struct packed {
        logic [`NCOMP_TAGW-1:0]        tag;
        logic [`OP_BITS-1:0]           op;
        logic [`FRM_BITS-1:0]          frm;
        logic [`NCOMP_LANES-1:0][31:0] dataa;
        logic [`NCOMP_LANES-1:0][31:0] datab;
    } ncomp_req_t;

    // Result stream entry
    typedef struct packed {
        logic [`NCOMP_TAGW-1:0]        tag;
        logic [`NCOMP_LANES-1:0][31:0] result;
        logic                          has_fflags; // Flags valid for the CSR
        fflags_t [`NCOMP_LANES-1:0]    fflags;
    } ncomp_rsp_t;

endpackage

// ==== rtl/pipe_stage.sv ====
`timescale 1ns/1ps

module pipe_stage #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic rst_n,
    input  logic enable,
    input  logic valid_in,
    input  T     data_in,
    output logic valid_out,
    output T     data_out
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
        end else if (enable) begin
            valid_out <= valid_in;
        end
    end

    always_ff @(posedge clk) begin
        if (enable) begin
            data_out <= data_in; // Payload held while stalled
        end
    end

endmodule

// ==== sim/ncomp_ref_model.svh ====
`ifndef NCOMP_REF_MODEL_SVH
`define NCOMP_REF_MODEL_SVH

function automatic logic ref_is_nan(input logic [31:0] x);
    return (x[30:23] == 8'hff) && (x[22:0] != 23'd0);
endfunction

function automatic logic ref_is_snan(input logic [31:0] x);
    return ref_is_nan(x) && !x[22];
endfunction

// Monotonic position on the real line with both zeros on one point
function automatic logic [31:0] order_key(input logic [31:0] x);
    if (x[30:0] == 31'd0) begin
        return 32'h8000_0000;
    end
    return x[31] ? ~x : {1'b1, x[30:0]};
endfunction

function automatic logic [31:0] fclass_mask(input logic [31:0] x);
    int bit_idx;
    if (ref_is_nan(x)) begin
        bit_idx = x[22] ? 9 : 8;
    end else if (x[30:23] == 8'hff) begin
        bit_idx = x[31] ? 0 : 7;
    end else if (x[30:23] != 8'h00) begin
        bit_idx = x[31] ? 1 : 6;
    end else if (x[22:0] != 23'd0) begin
        bit_idx = x[31] ? 2 : 5;
    end else begin
        bit_idx = x[31] ? 3 : 4;
    end
    return 32'd1 << bit_idx;
endfunction

function automatic logic [31:0] min_max(input logic [31:0] a, input logic [31:0] b,
                                        input logic is_max);
    logic a_first;
    if (ref_is_nan(a) && ref_is_nan(b)) begin
        return 32'h7fc0_0000;
    end
    if (ref_is_nan(a)) begin
        return b;
    end
    if (ref_is_nan(b)) begin
        return a;
    end
    // -0 just below +0 here
    a_first = (order_key(a) < order_key(b)) || (a == 32'h8000_0000 && b == 32'h0);
    return (a_first ^ is_max) ? a : b;
endfunction

function automatic ncomp_rsp_t expected_rsp(input ncomp_req_t r);
    ncomp_rsp_t  e;
    logic [31:0] a;
    logic [31:0] b;
    logic        any_nan;
    logic        any_snan;
    e            = '0;
    e.tag        = r.tag;
    e.has_fflags = (r.op == `OP_CMP) || (r.op == `OP_MISC && r.frm < 3'd2);
    for (int i = 0; i < `NCOMP_LANES; i++) begin
        a        = r.dataa[i];
        b        = r.datab[i];
        any_nan  = ref_is_nan(a) || ref_is_nan(b);
        any_snan = ref_is_snan(a) || ref_is_snan(b);
        case (r.op)
            `OP_CLASS: e.result[i] = fclass_mask(a);
            `OP_CMP: begin
                if (r.frm <= 3'd2) begin
                    e.fflags[i].NV = (r.frm == 3'd2) ? any_snan : any_nan; // FEQ is quiet
                end
                if (!any_nan) begin
                    case (r.frm)
                        3'd0:    e.result[i][0] = order_key(a) <= order_key(b);
                        3'd1:    e.result[i][0] = order_key(a) < order_key(b);
                        3'd2:    e.result[i][0] = order_key(a) == order_key(b);
                        default: e.result[i] = '0;
                    endcase
                end
            end
            `OP_MISC: begin
                case (r.frm)
                    3'd0, 3'd1: begin
                        e.result[i]    = min_max(a, b, r.frm[0]);
                        e.fflags[i].NV = any_snan;
                    end
                    3'd2:    e.result[i] = {b[31], a[30:0]};
                    3'd3:    e.result[i] = {~b[31], a[30:0]};
                    3'd4:    e.result[i] = {a[31] ^ b[31], a[30:0]};
                    default: e.result[i] = a;
                endcase
            end
            default: ;
        endcase
    end
    return e;
endfunction

`endif

// ==== sim/tb_fpu_ncomp.sv ====
`timescale 1ns/1ps
`include "fpu_defines.svh"

module tb_fpu_ncomp import fpu_pkg::*; ();

    localparam int LANES      = `NCOMP_LANES;
    localparam int MAX_CYCLES = 4000;
    localparam int N_RANDOM   = 300;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    logic                   req_ready;
    ncomp_req_t             req;
    logic                   rsp_valid;
    logic                   rsp_ready;
    ncomp_rsp_t             rsp;
    logic                   csr_req;
    logic                   csr_clear;
    logic                   csr_ack;
    fflags_t                csr_rdata;

    ncomp_rsp_t             exp_q[$];
    ncomp_rsp_t             exp_head;
    logic                   exp_empty;
    fflags_t                exp_acc;
    fflags_t                exp_rdata;
    ncomp_rsp_t             rsp_prev;
    logic [1:0]             accept_hist; // Request accepts of the last two edges
    logic                   lat_mode;   // rsp_ready pinned high
    logic                   rand_ready;
    int                     cycles;
    logic [`NCOMP_TAGW-1:0] tag_cnt;
    logic [31:0]            corners [16];

    `include "ncomp_ref_model.svh"

    fpu_ncomp_top u_dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic send_req(input logic [1:0] op, input logic [2:0] frm,
                            input logic [LANES-1:0][31:0] a, input logic [LANES-1:0][31:0] b);
        req.tag   = tag_cnt;
        req.op    = op;
        req.frm   = frm;
        req.dataa = a;
        req.datab = b;
        req_valid = 1'b1;
        @(posedge clk);
        while (!req_ready) @(posedge clk);
        #1;
        req_valid = 1'b0;
        tag_cnt++;
    endtask

    task automatic drain_pipe();
        rand_ready = 1'b0;
        @(posedge clk);
        #1;
        while (!exp_empty || rsp_valid) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic csr_read(input logic clear);
        drain_pipe();
        exp_rdata = exp_acc;
        csr_clear = clear;
        csr_req   = 1'b1;
        @(posedge clk);
        while (!csr_ack) @(posedge clk);
        #1;
        csr_req   = 1'b0;
        csr_clear = 1'b0;
        @(posedge clk);
        while (csr_ack) @(posedge clk);
        #1;
        if (clear) begin
            exp_acc = '0;
        end
    endtask

    // Scoreboard and cycle limit
    always @(posedge clk) begin
        ncomp_rsp_t done;
        if (!rst_n) begin
            exp_q.delete();
            accept_hist <= '0;
        end else begin
            if (rsp_valid && rsp_ready && exp_q.size() > 0) begin
                done = exp_q.pop_front();
                if (done.has_fflags) begin
                    for (int i = 0; i < LANES; i++) begin
                        exp_acc = exp_acc | done.fflags[i];
                    end
                end
            end
            if (req_valid && req_ready) begin
                exp_q.push_back(expected_rsp(req));
            end
            accept_hist <= {accept_hist[0], req_valid && req_ready};
        end
        exp_empty = (exp_q.size() == 0);
        exp_head  = exp_empty ? '0 : exp_q[0];
        rsp_prev <= rsp;
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            stop_on_error($sformatf("Timeout: the run did not finish in %0d cycles", cycles));
        end
    end

    always @(posedge clk) begin
        #1;
        rsp_ready = rand_ready ? (($urandom % 4) != 0) : 1'b1;
        lat_mode  = !rand_ready;
    end

    a_rsp_known: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_valid && rsp_ready |-> !exp_empty)
        else stop_on_error("A response left the DUT with no request outstanding");

    a_rsp_value: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_valid && rsp_ready |-> rsp == exp_head)
        else stop_on_error($sformatf("Error: rsp = %h, expected %h",
                                     $sampled(rsp), $sampled(exp_head)));

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
            lat_mode && $past(lat_mode, 2) |-> rsp_valid == accept_hist[1])
        else stop_on_error($sformatf("Error: rsp_valid = %h, expected %h",
                                     $sampled(rsp_valid), $sampled(accept_hist[1])));

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
            $past(rsp_valid && !rsp_ready) |-> rsp_valid && rsp == rsp_prev)
        else stop_on_error($sformatf("Error: rsp_valid = %h, rsp = %h in a stall, expected 1, %h",
                                     $sampled(rsp_valid), $sampled(rsp), $sampled(rsp_prev)));

    a_stall_ready: assert property (@(posedge clk) disable iff (!rst_n)
            rsp_valid && !rsp_ready |-> !req_ready)
        else stop_on_error($sformatf("Error: req_ready = %h in a stall, expected 0",
                                     $sampled(req_ready)));

    a_reset_state: assert property (@(posedge clk)
            rst_n && !$past(rst_n) |-> !rsp_valid && !csr_ack && req_ready)
        else stop_on_error($sformatf(
            "Error: rsp_valid = %h, csr_ack = %h, req_ready = %h, expected 0, 0, 1",
            $sampled(rsp_valid), $sampled(csr_ack), $sampled(req_ready)));

    a_ack_rise: assert property (@(posedge clk) disable iff (!rst_n)
            csr_ack && !$past(csr_ack) |-> $past(csr_req))
        else stop_on_error("csr_ack rose without a pending csr_req");

    a_ack_fall: assert property (@(posedge clk) disable iff (!rst_n)
            !csr_ack && $past(csr_ack) |-> !$past(csr_req))
        else stop_on_error("csr_ack fell while csr_req was still high");

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
            csr_ack && !$past(csr_ack) |-> csr_rdata == exp_rdata)
        else stop_on_error($sformatf("Error: csr_rdata = %h, expected %h",
                                     $sampled(csr_rdata), $sampled(exp_rdata)));

    initial begin
        logic [LANES-1:0][31:0] a;
        logic [LANES-1:0][31:0] b;
        void'($urandom(32'h491c_e374));
        // Zeros, subnormals, infinities, NaNs, then +-1 and +-2 on xor-friendly slots
        corners = '{32'h0000_0000, 32'h8000_0000, 32'h0000_0001, 32'h807f_ffff,
                    32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000, 32'h7f80_0001,
                    32'h3f80_0000, 32'hbf80_0000, 32'h4000_0000, 32'hc000_0000,
                    32'h007f_ffff, 32'h8000_0001, 32'hffc0_0001, 32'hff90_0000};
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b1;
        csr_req    = 1'b0;
        csr_clear  = 1'b0;
        exp_acc    = '0;
        exp_rdata  = '0;
        lat_mode   = 1'b1;
        rand_ready = 1'b0;
        tag_cnt    = '0;
        cycles     = 0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int pass = 0; pass < 2; pass++) begin
            for (int op = 0; op < 3; op++) begin
                for (int frm = 0; frm < 8; frm++) begin
                    if (op == 0 && frm > 0) continue; // FCLASS ignores frm
                    for (int i = 0; i < 16; i++) begin
                        a[0] = corners[i];
                        a[1] = corners[i];
                        b[0] = corners[(pass == 1) ? i : (i ^ 1)]; // Equal pairs on pass 1
                        b[1] = corners[i ^ ((pass == 1) ? 3 : 2)];
                        send_req(op[1:0], frm[2:0], a, b);
                    end
                end
            end
        end
        csr_read(1'b1);
        csr_read(1'b0);

        rand_ready = 1'b1;
        for (int n = 0; n < N_RANDOM; n++) begin
            for (int l = 0; l < LANES; l++) begin
                a[l] = ($urandom % 2 == 1) ? corners[$urandom % 16] : $urandom;
                b[l] = ($urandom % 2 == 1) ? corners[$urandom % 16] : $urandom;
            end
            send_req(2'($urandom % 3), 3'($urandom % 8), a, b);
            if ($urandom % 5 == 0) begin
                @(posedge clk);
                #1;
            end
        end
        csr_read(1'b1);
        csr_read(1'b0);

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
